// File: bench/scheduler_model.svh
`ifndef SCHEDULER_MODEL_SVH
`define SCHEDULER_MODEL_SVH

// ==================================================
// Expected state of the issue stage
// ==================================================

// Architectural registers as the register file should hold them
data_word_t golden_regs [0:31];

// Pending results, entry k reaches the write-back port k+1 edges from now
logic       sb_valid    [0:MAX_LATENCY-1];
reg_idx_t   sb_dest     [0:MAX_LATENCY-1];

// Cycles the divider stays occupied, zero when idle
int         div_left;

// Tag that the next issued instruction receives
int         tag_count;

// Cycles from issue to write-back for each unit
function automatic int result_latency(exu_unit_t unit);
    case (unit)
        EXU_ALU: return ALU_LATENCY;
        EXU_MUL: return MUL_LATENCY;
        EXU_DIV: return DIV_LATENCY;
        default: return LDU_LATENCY;
    endcase
endfunction

// Reset and flush both drop every result in flight and restart the tags
task automatic clear_state();
    for (int k = 0; k < MAX_LATENCY; k++) begin
        sb_valid[k] = 1'b0;
        sb_dest[k]  = '0;
    end
    div_left  = 0;
    tag_count = 0;
endtask

// Applies one rising clock edge to the expected state
task automatic advance_state(decoded_instr_t ins, writeback_t wb, logic issued, logic flush);
    int lat;
    lat = result_latency(ins.unit);
    // The register file takes the write-back even in a flush cycle
    if (wb.valid && (wb.dest_reg != '0)) begin
        golden_regs[wb.dest_reg] = wb.data;
    end
    if (flush) begin
        clear_state();
    end else begin
        // Everything in flight moves one cycle closer to write-back
        for (int k = 0; k < MAX_LATENCY - 1; k++) begin
            sb_valid[k] = sb_valid[k+1];
            sb_dest[k]  = sb_dest[k+1];
        end
        sb_valid[MAX_LATENCY-1] = 1'b0;
        sb_dest[MAX_LATENCY-1]  = '0;
        if (div_left > 0) begin
            div_left--;
        end
        if (issued) begin
            if (ins.writes_dest) begin
                sb_valid[lat-1] = 1'b1;
                sb_dest[lat-1]  = ins.dest_reg;
            end
            // The divider frees up in the cycle of its own write-back
            if (ins.unit == EXU_DIV) begin
                div_left = DIV_LATENCY - 1;
            end
            tag_count = (tag_count + 1) % ROB_DEPTH;
        end
    end
endtask

`endif

// File: bench/scheduler_tb.sv
`timescale 1ns/100ps

module scheduler_tb;

    import issue_pkg::*;

    localparam int ROB_DEPTH = 32;
    localparam int N_INSTR   = 2000;
    // Worst case per instruction plus the register fill after reset
    localparam int TIMEOUT_CYCLES = N_INSTR * (MAX_LATENCY + 4) + 64;

    logic           clk_i;
    logic           rst_n_i;
    logic           flush_i;
    logic           stall_i;
    logic           stop_tag_i;
    decoded_instr_t instr_i;
    writeback_t     writeback_i;
    issue_packet_t  issue_o;
    logic           stall_o;

    logic [15:0]    lfsr_state;
    int             cycle_count;

    // Results the functional units still owe, with the cycles left until each is due
    reg_idx_t       wb_dest_q [$];
    int             wb_left_q [$];

    `include "scheduler_model.svh"

    scheduler #(
        .ROB_DEPTH ( ROB_DEPTH )
    ) scheduler_i (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .flush_i     ( flush_i     ),
        .stall_i     ( stall_i     ),
        .stop_tag_i  ( stop_tag_i  ),
        .instr_i     ( instr_i     ),
        .writeback_i ( writeback_i ),
        .issue_o     ( issue_o     ),
        .stall_o     ( stall_o     )
    );

    // ==================================================
    // Clock and timeout
    // ==================================================

    initial begin
        clk_i       = 1'b0;
        cycle_count = 0;
    end

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("The run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // ==================================================
    // Random stimulus
    // ==================================================

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    // Registers come from x0..x7 so that dependencies show up often
    function automatic decoded_instr_t random_instr();
        decoded_instr_t ins;
        ins.valid        = (next_bits(3) != 0);
        ins.unit         = exu_unit_t'(2'(next_bits(2)));
        ins.dest_reg     = reg_idx_t'(next_bits(3));
        ins.writes_dest  = (next_bits(2) != 0);
        ins.src_reg[0]   = reg_idx_t'(next_bits(3));
        ins.src_reg[1]   = reg_idx_t'(next_bits(3));
        ins.imm_valid[0] = (next_bits(2) == 0);
        ins.imm_valid[1] = (next_bits(2) == 0);
        ins.immediate[0] = next_bits(32);
        ins.immediate[1] = next_bits(32);
        ins.save_next_pc = (next_bits(3) == 0);
        ins.compressed   = (next_bits(1) != 0);
        ins.fence        = (next_bits(4) == 0);
        return ins;
    endfunction

    // Plays the functional units, one result per cycle at most
    task automatic drive_writeback();
        int due;
        int n_due;
        due   = -1;
        n_due = 0;
        for (int p = 0; p < wb_left_q.size(); p++) begin
            if (wb_left_q[p] == 1) begin
                due = p;
                n_due++;
            end
        end
        if (n_due > 1) begin
            $display("Two results are due on the write-back port in the same cycle");
            $display("Testbench failed");
            $fatal(1, "write-back port collision");
        end else begin
            writeback_i = '0;
            if (due >= 0) begin
                writeback_i.valid    = 1'b1;
                writeback_i.dest_reg = wb_dest_q[due];
                writeback_i.data     = next_bits(32);
                wb_dest_q.delete(due);
                wb_left_q.delete(due);
            end
            foreach (wb_left_q[p]) begin
                wb_left_q[p]--;
            end
        end
    endtask

    // ==================================================
    // Expected outputs
    // ==================================================

    // RAW, divider, write-back port and fence conditions, then the full ROB
    function automatic logic predict_stall(decoded_instr_t ins, logic stop);
        logic [1:0] reads;
        logic       hit;
        logic       empty;
        int         lat;
        // A link instruction replaces its second operand with the increment
        reads[0] = ins.save_next_pc || !ins.imm_valid[0];
        reads[1] = !ins.save_next_pc && !ins.imm_valid[1];
        lat      = result_latency(ins.unit);
        hit      = (ins.unit == EXU_DIV) && (div_left > 0);
        empty    = (div_left == 0);
        for (int k = 0; k < MAX_LATENCY; k++) begin
            if (sb_valid[k]) begin
                empty = 1'b0;
                // Entry 0 is on the write-back port now and gets forwarded
                for (int s = 0; s < 2; s++) begin
                    if ((k >= 1) && reads[s] && (ins.src_reg[s] != '0) &&
                        (sb_dest[k] == ins.src_reg[s])) begin
                        hit = 1'b1;
                    end
                end
            end
        end
        if (ins.writes_dest && (lat < MAX_LATENCY)) begin
            if (sb_valid[lat]) begin
                hit = 1'b1;
            end
        end
        if (ins.fence && !empty) begin
            hit = 1'b1;
        end
        return hit || stop;
    endfunction

    function automatic issue_packet_t predict_packet(decoded_instr_t ins, writeback_t wb,
                                                     logic valid);
        issue_packet_t pkt;
        data_word_t    src [0:1];
        for (int i = 0; i < 2; i++) begin
            if (wb.valid && (ins.src_reg[i] != '0) && (wb.dest_reg == ins.src_reg[i])) begin
                src[i] = wb.data;
            end else begin
                src[i] = golden_regs[ins.src_reg[i]];
            end
        end
        pkt.valid    = valid;
        pkt.unit     = ins.unit;
        pkt.dest_reg = ins.dest_reg;
        pkt.rob_tag  = rob_tag_t'(tag_count);
        if (ins.save_next_pc) begin
            pkt.operand[0] = src[0];
            pkt.operand[1] = ins.compressed ? 32'd2 : 32'd4;
            pkt.imm_valid  = 2'b01;
        end else begin
            for (int i = 0; i < 2; i++) begin
                pkt.operand[i] = ins.imm_valid[i] ? ins.immediate[0] : src[i];
            end
            pkt.imm_valid = ins.imm_valid;
        end
        return pkt;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================

    task automatic check_stall(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error %s expected %b actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stall mismatch");
        end
    endtask

    task automatic check_packet(string name, issue_packet_t expected, issue_packet_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "issue packet mismatch");
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        issue_packet_t exp_pkt;
        logic          exp_stall;
        logic          issued;
        logic          held;
        int            n_issued;
        int            n_stalls;
        int            n_flushes;

        lfsr_state  = 16'd29682;
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        stall_i     = 1'b0;
        stop_tag_i  = 1'b0;
        instr_i     = '0;
        writeback_i = '0;
        held        = 1'b0;
        n_issued    = 0;
        n_stalls    = 0;
        n_flushes   = 0;
        golden_regs[0] = '0;
        clear_state();

        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Give every register a known value through the write-back port
        for (int r = 1; r < 32; r++) begin
            writeback_i.valid    = 1'b1;
            writeback_i.dest_reg = reg_idx_t'(r);
            writeback_i.data     = next_bits(32);
            #2;
            advance_state(instr_i, writeback_i, 1'b0, 1'b0);
            @(posedge clk_i);
            #1;
        end

        while (n_issued < N_INSTR) begin
            drive_writeback();
            // Decode keeps a blocked instruction in place
            if (!held) begin
                instr_i = random_instr();
            end
            stall_i    = (next_bits(3) == 0);
            stop_tag_i = (next_bits(4) == 0);
            flush_i    = (next_bits(7) == 0);

            // Outputs are settled one nanosecond before the edge
            #2;
            exp_stall = predict_stall(instr_i, stop_tag_i);
            issued    = instr_i.valid && !exp_stall && !stall_i && !flush_i;
            exp_pkt   = predict_packet(instr_i, writeback_i, issued);
            check_stall($sformatf("stall_o cycle %0d", cycle_count), exp_stall, stall_o);
            check_packet($sformatf("issue_o cycle %0d", cycle_count), exp_pkt, issue_o);

            if (issued && instr_i.writes_dest) begin
                wb_dest_q.push_back(instr_i.dest_reg);
                wb_left_q.push_back(result_latency(instr_i.unit));
            end
            // Flushed results never come back from the units
            if (flush_i) begin
                wb_dest_q.delete();
                wb_left_q.delete();
                n_flushes++;
            end
            n_issued += issued ? 1 : 0;
            n_stalls += exp_stall ? 1 : 0;
            held = instr_i.valid && !issued && !flush_i;
            advance_state(instr_i, writeback_i, issued, flush_i);

            @(posedge clk_i);
            #1;
        end

        $display("Issued %0d instructions, %0d stall cycles, %0d flushes",
                 n_issued, n_stalls, n_flushes);
        $display("Testbench passed");
        $finish;
    end

endmodule : scheduler_tb

// File: hw/issue_pkg.sv
package issue_pkg;

    // ==================================================
    // Basic datapath types
    // ==================================================

    // One architectural data word
    typedef logic [31:0] data_word_t;

    // Index into the 32 entry integer register file
    typedef logic [4:0] reg_idx_t;

    // Functional unit that will execute the instruction
    typedef enum logic [1:0] {
        EXU_ALU,
        EXU_MUL,
        EXU_DIV,
        EXU_LDU
    } exu_unit_t;

    // Result latencies in cycles from issue to write-back
    localparam int ALU_LATENCY = 1;
    localparam int LDU_LATENCY = 2;
    // The multiplier is pipelined and accepts a new operation every cycle
    localparam int MUL_LATENCY = 3;
    // The divider holds a single operation until its result is out
    localparam int DIV_LATENCY = 8;

    // Longest latency, which also sets the depth of the result shift register
    localparam int MAX_LATENCY = 8;

    // Reorder buffer tags wrap over 2^ROB_TAG_BITS entries
    localparam int ROB_TAG_BITS = 5;
    typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;

    // Maps a functional unit to the number of cycles until its result
    function automatic int unit_latency(exu_unit_t unit);
        case (unit)
            EXU_ALU: return ALU_LATENCY;
            EXU_MUL: return MUL_LATENCY;
            EXU_DIV: return DIV_LATENCY;
            default: return LDU_LATENCY;
        endcase
    endfunction

    // ==================================================
    // Packets crossing the issue stage
    // ==================================================

    // Instruction offered by decode, held stable while the stage stalls
    typedef struct packed {
        logic                valid;
        exu_unit_t           unit;
        reg_idx_t            dest_reg;
        logic                writes_dest;
        reg_idx_t [1:0]      src_reg;
        logic [1:0]          imm_valid;
        data_word_t [1:0]    immediate;
        logic                save_next_pc;
        logic                compressed;
        logic                fence;
    } decoded_instr_t;

    // Instruction leaving the stage with its operands resolved
    typedef struct packed {
        logic                valid;
        exu_unit_t           unit;
        reg_idx_t            dest_reg;
        rob_tag_t            rob_tag;
        data_word_t [1:0]    operand;
        logic [1:0]          imm_valid;
    } issue_packet_t;

    // Result returning from a functional unit
    typedef struct packed {
        logic                valid;
        reg_idx_t            dest_reg;
        data_word_t          data;
    } writeback_t;

endpackage : issue_pkg

// File: hw/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                        clk_i,

    // Two source operand read ports
    input  issue_pkg::reg_idx_t [1:0]   read_addr_i,
    output issue_pkg::data_word_t [1:0] read_data_o,

    // Single write-back port
    input  issue_pkg::writeback_t       write_i
);

    import issue_pkg::*;

    // ==================================================
    // Storage
    // ==================================================

    // Entry 0 is never written so x0 keeps no real state
    data_word_t reg_mem [0:31];

    // A write to x0 is dropped here as well as on the read side
    always_ff @(posedge clk_i) begin
        if (write_i.valid && (write_i.dest_reg != '0)) begin
            reg_mem[write_i.dest_reg] <= write_i.data;
        end
    end

    // ==================================================
    // Read ports
    // ==================================================

    // Reads are combinational, the scheduler forwards a same cycle write-back
    // on top of this value when the register matches
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (read_addr_i[i] == '0) begin
                // Hardwired zero register
                read_data_o[i] = '0;
            end else begin
                read_data_o[i] = reg_mem[read_addr_i[i]];
            end
        end
    end

endmodule : register_file

// File: hw/scheduler.sv
`timescale 1ns/100ps

module scheduler #(
    // Reorder buffer entry count matching the tag width in the package
    parameter int ROB_DEPTH = 32
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Back-pressure from execute
    input  logic                      stall_i,

    // Reorder buffer has no free entry
    input  logic                      stop_tag_i,

    // Instruction from decode
    input  issue_pkg::decoded_instr_t instr_i,

    // Result from the functional units
    input  issue_pkg::writeback_t     writeback_i,

    // Instruction to execute and stall back to decode
    output issue_pkg::issue_packet_t  issue_o,
    output logic                      stall_o
);

    import issue_pkg::*;

    // ==================================================
    // Register file
    // ==================================================

    data_word_t [1:0] rf_data;

    register_file reg_file_i (
        .clk_i       ( clk_i           ),
        .read_addr_i ( instr_i.src_reg ),
        .read_data_o ( rf_data         ),
        .write_i     ( writeback_i     )
    );

    // ==================================================
    // Scoreboard
    // ==================================================

    logic hazard;
    logic sb_empty;
    logic issue;

    scoreboard scoreboard_i (
        .clk_i    ( clk_i    ),
        .rst_n_i  ( rst_n_i  ),
        .flush_i  ( flush_i  ),
        .instr_i  ( instr_i  ),
        .issue_i  ( issue    ),
        .hazard_o ( hazard   ),
        .empty_o  ( sb_empty )
    );

    // ==================================================
    // Issue control
    // ==================================================

    logic fence_wait;

    // Fence waits for every in-flight result and for the divider to drain
    assign fence_wait = instr_i.fence & ~sb_empty;

    assign stall_o = hazard | fence_wait | stop_tag_i;

    // Flush wins over everything so nothing leaves the stage in that cycle
    assign issue = instr_i.valid & ~stall_o & ~stall_i & ~flush_i;

    // ==================================================
    // Operand selection
    // ==================================================

    logic [1:0]       fwd_hit;
    data_word_t [1:0] src_data;
    data_word_t [1:0] operand;
    logic [1:0]       imm_valid;

    // Write-back data bypasses the register file in the cycle it is written
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // x0 is never forwarded, even if a unit reports a write to it
            fwd_hit[i] = writeback_i.valid && (instr_i.src_reg[i] != '0) &&
                         (writeback_i.dest_reg == instr_i.src_reg[i]);
            src_data[i] = fwd_hit[i] ? writeback_i.data : rf_data[i];
        end
    end

    always_comb begin
        operand   = '0;
        imm_valid = instr_i.imm_valid;

        if (instr_i.save_next_pc) begin
            // Jump and link keeps the base register as operand 0
            operand[0] = src_data[0];
            // The ALU adds 2 or 4 to the instruction address for the link value
            operand[1] = instr_i.compressed ? data_word_t'(2) : data_word_t'(4);
            imm_valid  = 2'b01;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // Decode places the single immediate in the first slot
                operand[i] = instr_i.imm_valid[i] ? instr_i.immediate[0] : src_data[i];
            end
        end
    end

    // ==================================================
    // Reorder buffer tag
    // ==================================================

    rob_tag_t tag_q;

    // The packet carries the current value and the counter moves on the issue edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tag_q <= '0;
        end else if (flush_i) begin
            tag_q <= '0;
        end else if (issue) begin
            if (tag_q == rob_tag_t'(ROB_DEPTH - 1)) begin
                tag_q <= '0;
            end else begin
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    // ==================================================
    // Issue packet
    // ==================================================

    // Zero latency path from decode to execute
    always_comb begin
        issue_o.valid     = issue;
        issue_o.unit      = instr_i.unit;
        issue_o.dest_reg  = instr_i.dest_reg;
        issue_o.rob_tag   = tag_q;
        issue_o.operand   = operand;
        issue_o.imm_valid = imm_valid;
    end

    // ==================================================
    // Assertions
    // ==================================================

    // Tag counter wraps on ROB_DEPTH while the packet field uses the package width
    a_rob_depth_pow2: assert property (@(posedge clk_i)
        ROB_DEPTH == (1 << ROB_TAG_BITS))
        else $error("ROB_DEPTH does not match the tag width");

    // Back-pressure leaves the tag in place unless a flush restarts it
    a_no_issue_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> (tag_q == $past(tag_q)))
        else $error("Instruction issued while execute stalled");

endmodule : scheduler

// File: hw/scoreboard.sv
`timescale 1ns/100ps

module scoreboard (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Instruction waiting at issue and the strobe that it actually left
    input  issue_pkg::decoded_instr_t instr_i,
    input  logic                      issue_i,

    output logic                      hazard_o,
    output logic                      empty_o
);

    import issue_pkg::*;

    // Divider occupancy counter width
    localparam int DIV_CNT_W = $clog2(DIV_LATENCY);

    // Divider FSM that stays in BUSY while an operation is still inside the unit
    typedef enum logic {
        SB_IDLE,
        SB_BUSY
    } sb_state_t;

    // One pending write-back
    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
    } slot_t;

    // ==================================================
    // Result shift register
    // ==================================================

    // Slot k holds a result that reaches the write-back port k+1 edges from now
    slot_t [MAX_LATENCY-1:0] slots_q;
    slot_t [MAX_LATENCY-1:0] slots_next;

    int issue_lat;

    assign issue_lat = unit_latency(instr_i.unit);

    always_comb begin
        // Every slot moves one step closer to write-back each cycle
        for (int k = 0; k < MAX_LATENCY - 1; k++) begin
            slots_next[k] = slots_q[k+1];
        end
        slots_next[MAX_LATENCY-1] = '0;

        // A new writing instruction lands at slot L-1 after the shift
        if (issue_i && instr_i.writes_dest) begin
            slots_next[issue_lat-1].valid = 1'b1;
            slots_next[issue_lat-1].dest  = instr_i.dest_reg;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slots_q <= '0;
        end else if (flush_i) begin
            // Results of flushed instructions are discarded downstream
            slots_q <= '0;
        end else begin
            slots_q <= slots_next;
        end
    end

    // ==================================================
    // Divider occupancy
    // ==================================================

    sb_state_t            div_state_q;
    sb_state_t            div_state_next;
    logic [DIV_CNT_W-1:0] div_count_q;
    logic [DIV_CNT_W-1:0] div_count_next;
    logic                 div_start;

    assign div_start = issue_i && (instr_i.unit == EXU_DIV);

    always_comb begin
        div_state_next = div_state_q;
        div_count_next = div_count_q;

        case (div_state_q)
            SB_IDLE: begin
                // Counter expires in the cycle the divider result is written back
                if (div_start) begin
                    div_count_next = DIV_CNT_W'(DIV_LATENCY - 1);
                    div_state_next = SB_BUSY;
                end
            end

            SB_BUSY: begin
                div_count_next = div_count_q - 1'b1;
                if (div_count_q == DIV_CNT_W'(1)) begin
                    div_state_next = SB_IDLE;
                end
            end

            default: begin
                div_state_next = SB_IDLE;
                div_count_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            div_state_q <= SB_IDLE;
            div_count_q <= '0;
        end else if (flush_i) begin
            div_state_q <= SB_IDLE;
            div_count_q <= '0;
        end else begin
            div_state_q <= div_state_next;
            div_count_q <= div_count_next;
        end
    end

    // ==================================================
    // Hazard detection
    // ==================================================

    logic [1:0] src_used;
    logic       raw_hazard;
    logic       div_hazard;
    logic       wb_collision;

    // A link instruction reads only its first source because operand 1 carries the increment
    assign src_used[0] = instr_i.save_next_pc | ~instr_i.imm_valid[0];
    assign src_used[1] = ~instr_i.save_next_pc & ~instr_i.imm_valid[1];

    always_comb begin
        raw_hazard = 1'b0;
        // Slot 0 is skipped because its data is on the write-back port right now
        for (int s = 0; s < 2; s++) begin
            for (int k = 1; k < MAX_LATENCY; k++) begin
                if (src_used[s] && (instr_i.src_reg[s] != '0) && slots_q[k].valid &&
                    (slots_q[k].dest == instr_i.src_reg[s])) begin
                    raw_hazard = 1'b1;
                end
            end
        end
    end

    // Non pipelined divider cannot take a second operation
    assign div_hazard = (instr_i.unit == EXU_DIV) && (div_state_q == SB_BUSY);

    always_comb begin
        wb_collision = 1'b0;
        // Slot L shifts into slot L-1 exactly where the new result would go
        if (instr_i.writes_dest && (issue_lat < MAX_LATENCY)) begin
            wb_collision = slots_q[issue_lat].valid;
        end
    end

    assign hazard_o = raw_hazard | div_hazard | wb_collision;
    assign empty_o  = (slots_q == '0) && (div_state_q == SB_IDLE);

    // ==================================================
    // Assertions
    // ==================================================

    // The scheduler never lets two results claim the same write-back cycle
    a_single_wb_per_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (issue_i && instr_i.writes_dest) |-> !wb_collision)
        else $error("Two write-backs scheduled in the same cycle");

    // The divider leaves BUSY before its counter could wrap below zero
    a_div_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (div_state_q == SB_BUSY) |-> (div_count_q != '0))
        else $error("Divider busy counter wrapped below zero");

endmodule : scoreboard

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module scheduler_tb \
    -o scheduler_sim > build.log 2>&1 || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/scheduler_sim > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }

// File: sim.f
+incdir+bench
hw/issue_pkg.sv
hw/register_file.sv
hw/scoreboard.sv
hw/scheduler.sv
bench/scheduler_tb.sv
